//--- Bender.yml
package:
  name: retire_trace

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rvfi_pkg.sv
      - hdl/trace_pkg.sv
      - hdl/rvc_expander.sv
      - hdl/retire_packer.sv
      - hdl/trace_arbiter.sv
      - hdl/trace_buffer.sv
      - hdl/retire_trace_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/tb_retire_trace.sv

//--- hdl/retire_packer.sv
// ************************************************
// Retire packer
// Builds a stamped trace record per retirement and
// holds it in a short queue until granted
// ************************************************

`default_nettype none

`include "retire_trace_consts.svh"

module retire_packer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  valid_i,
  input  rvfi_pkg::insn_t       insn_i,
  input  rvfi_pkg::xlen_t       pc_i,
  input  rvfi_pkg::reg_addr_t   rd_addr_i,
  input  rvfi_pkg::xlen_t       rd_wdata_i,
  input  logic                  frd_wvalid_i,
  input  rvfi_pkg::reg_addr_t   frd_addr_i,
  input  rvfi_pkg::xlen_t       frd_wdata_i,
  input  logic                  gnt_i,
  output logic                  req_o,
  output rvfi_pkg::xlen_t       rec_pc_o,
  output rvfi_pkg::insn_t       rec_insn_o,
  output logic                  rec_cmp_o,
  output rvfi_pkg::reg_idx_t    rec_rd_o,
  output rvfi_pkg::xlen_t       rec_val_o,
  output trace_pkg::stamp_t     rec_stamp_o,
  output trace_pkg::drop_cnt_t  drop_o
);

  localparam int unsigned lvl_w = $clog2(`RT_QUEUE_DEPTH + 1);
  localparam int unsigned ptr_w = $clog2(`RT_QUEUE_DEPTH);

  rvfi_pkg::insn_t      exp_insn;
  logic                 exp_cmp;
  rvfi_pkg::reg_idx_t   rd_sel;
  rvfi_pkg::xlen_t      val_sel;
  trace_pkg::stamp_t    cycle_q;
  trace_pkg::drop_cnt_t drop_q;
  logic [lvl_w-1:0]     level_q;
  logic [ptr_w-1:0]     rd_ptr_q;
  logic [ptr_w-1:0]     wr_ptr_q;
  logic                 fresh_q;
  logic                 push;
  logic                 pop;

  // Queue storage, one array per record field
  rvfi_pkg::xlen_t    pc_q    [`RT_QUEUE_DEPTH];
  rvfi_pkg::insn_t    insn_q  [`RT_QUEUE_DEPTH];
  logic               cmp_q   [`RT_QUEUE_DEPTH];
  rvfi_pkg::reg_idx_t rd_q    [`RT_QUEUE_DEPTH];
  rvfi_pkg::xlen_t    val_q   [`RT_QUEUE_DEPTH];
  trace_pkg::stamp_t  stamp_q [`RT_QUEUE_DEPTH];

  rvc_expander expander_i (
    .insn_i      (insn_i),
    .insn_o      (exp_insn),
    .compressed_o(exp_cmp),
    .expanded_o  ()
  );

  // FP write wins over the integer write
  always_comb begin
    if (frd_wvalid_i) begin
      rd_sel  = {1'b1, frd_addr_i};
      val_sel = frd_wdata_i;
    end else begin
      rd_sel  = {1'b0, rd_addr_i};
      val_sel = rd_wdata_i;
    end
  end

  // A pop on the same edge frees room for the new record
  assign pop  = gnt_i;
  assign push = valid_i && ((level_q != lvl_w'(`RT_QUEUE_DEPTH)) || pop);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q  <= '0;
      drop_q   <= '0;
      level_q  <= '0;
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      fresh_q  <= 1'b0;
      for (int i = 0; i < `RT_QUEUE_DEPTH; i++) begin
        stamp_q[i] <= '0;
      end
    end else begin
      cycle_q <= cycle_q + 1'b1;
      fresh_q <= push;
      if (valid_i && !push && (drop_q != '1)) begin
        drop_q <= drop_q + 1'b1;
      end
      if (push) begin
        stamp_q[wr_ptr_q] <= cycle_q;
        wr_ptr_q          <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        level_q <= level_q + 1'b1;
      end else if (pop && !push) begin
        level_q <= level_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      pc_q[wr_ptr_q]   <= pc_i;
      insn_q[wr_ptr_q] <= exp_insn;
      cmp_q[wr_ptr_q]  <= exp_cmp;
      rd_q[wr_ptr_q]   <= rd_sel;
      val_q[wr_ptr_q]  <= val_sel;
    end
  end

  // A record pushed on the last edge is requested one cycle later
  assign req_o       = (level_q > lvl_w'(fresh_q));
  assign rec_pc_o    = pc_q[rd_ptr_q];
  assign rec_insn_o  = insn_q[rd_ptr_q];
  assign rec_cmp_o   = cmp_q[rd_ptr_q];
  assign rec_rd_o    = rd_q[rd_ptr_q];
  assign rec_val_o   = val_q[rd_ptr_q];
  assign rec_stamp_o = stamp_q[rd_ptr_q];
  assign drop_o      = drop_q;

  a_level_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    level_q <= lvl_w'(`RT_QUEUE_DEPTH));

  // Grants come from the arbiter and must follow our request
  a_gnt_needs_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_i |-> req_o);

endmodule

`default_nettype wire

//--- hdl/retire_trace_consts.svh
// ************************************************
// Retire trace constants
// Widths and depths shared by the trace capture
// blocks and their packages
// ************************************************

`ifndef RETIRE_TRACE_CONSTS_SVH
`define RETIRE_TRACE_CONSTS_SVH

// Data, PC and address width of the cores
`define RT_XLEN 32

// Cycle stamp carried by each record
`define RT_STAMP_W 16

// Shared trace buffer, depth and index width must agree
`define RT_DEPTH 16
`define RT_DEPTH_W 4

// Records held per hart while waiting for the buffer
`define RT_QUEUE_DEPTH 2

`endif

//--- hdl/retire_trace_top.sv
// ************************************************
// Retire trace top
// Two hart packers sharing one trace buffer
// ************************************************

`default_nettype none

module retire_trace_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rvfi0_valid_i,
  input  rvfi_pkg::insn_t      rvfi0_insn_i,
  input  rvfi_pkg::xlen_t      rvfi0_pc_i,
  input  rvfi_pkg::reg_addr_t  rvfi0_rd_addr_i,
  input  rvfi_pkg::xlen_t      rvfi0_rd_wdata_i,
  input  logic                 rvfi0_frd_wvalid_i,
  input  rvfi_pkg::reg_addr_t  rvfi0_frd_addr_i,
  input  rvfi_pkg::xlen_t      rvfi0_frd_wdata_i,
  input  logic                 rvfi1_valid_i,
  input  rvfi_pkg::insn_t      rvfi1_insn_i,
  input  rvfi_pkg::xlen_t      rvfi1_pc_i,
  input  rvfi_pkg::reg_addr_t  rvfi1_rd_addr_i,
  input  rvfi_pkg::xlen_t      rvfi1_rd_wdata_i,
  input  logic                 rvfi1_frd_wvalid_i,
  input  rvfi_pkg::reg_addr_t  rvfi1_frd_addr_i,
  input  rvfi_pkg::xlen_t      rvfi1_frd_wdata_i,
  input  logic                 clear_i,
  input  trace_pkg::buf_idx_t  rd_idx_i,
  output trace_pkg::buf_cnt_t  count_o,
  output logic                 full_o,
  output logic                 rd_hart_o,
  output rvfi_pkg::xlen_t      rd_pc_o,
  output rvfi_pkg::insn_t      rd_insn_o,
  output logic                 rd_cmp_o,
  output rvfi_pkg::reg_idx_t   rd_rd_o,
  output rvfi_pkg::xlen_t      rd_val_o,
  output trace_pkg::stamp_t    rd_stamp_o,
  output trace_pkg::drop_cnt_t drop0_o,
  output trace_pkg::drop_cnt_t drop1_o
);

  // Packer to arbiter
  logic               req0;
  logic               req1;
  logic               gnt0;
  logic               gnt1;
  rvfi_pkg::xlen_t    pc0;
  rvfi_pkg::xlen_t    pc1;
  rvfi_pkg::insn_t    insn0;
  rvfi_pkg::insn_t    insn1;
  logic               cmp0;
  logic               cmp1;
  rvfi_pkg::reg_idx_t rd0;
  rvfi_pkg::reg_idx_t rd1;
  rvfi_pkg::xlen_t    val0;
  rvfi_pkg::xlen_t    val1;
  trace_pkg::stamp_t  stamp0;
  trace_pkg::stamp_t  stamp1;

  // Arbiter to buffer
  logic               wr_en;
  logic               wr_hart;
  rvfi_pkg::xlen_t    wr_pc;
  rvfi_pkg::insn_t    wr_insn;
  logic               wr_cmp;
  rvfi_pkg::reg_idx_t wr_rd;
  rvfi_pkg::xlen_t    wr_val;
  trace_pkg::stamp_t  wr_stamp;

  retire_packer packer0_i (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .valid_i(rvfi0_valid_i), .insn_i(rvfi0_insn_i), .pc_i(rvfi0_pc_i),
    .rd_addr_i(rvfi0_rd_addr_i), .rd_wdata_i(rvfi0_rd_wdata_i),
    .frd_wvalid_i(rvfi0_frd_wvalid_i), .frd_addr_i(rvfi0_frd_addr_i),
    .frd_wdata_i(rvfi0_frd_wdata_i),
    .gnt_i(gnt0), .req_o(req0),
    .rec_pc_o(pc0), .rec_insn_o(insn0), .rec_cmp_o(cmp0),
    .rec_rd_o(rd0), .rec_val_o(val0), .rec_stamp_o(stamp0),
    .drop_o(drop0_o)
  );

  retire_packer packer1_i (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .valid_i(rvfi1_valid_i), .insn_i(rvfi1_insn_i), .pc_i(rvfi1_pc_i),
    .rd_addr_i(rvfi1_rd_addr_i), .rd_wdata_i(rvfi1_rd_wdata_i),
    .frd_wvalid_i(rvfi1_frd_wvalid_i), .frd_addr_i(rvfi1_frd_addr_i),
    .frd_wdata_i(rvfi1_frd_wdata_i),
    .gnt_i(gnt1), .req_o(req1),
    .rec_pc_o(pc1), .rec_insn_o(insn1), .rec_cmp_o(cmp1),
    .rec_rd_o(rd1), .rec_val_o(val1), .rec_stamp_o(stamp1),
    .drop_o(drop1_o)
  );

  trace_arbiter arbiter_i (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .req0_i(req0), .pc0_i(pc0), .insn0_i(insn0), .cmp0_i(cmp0),
    .rd0_i(rd0), .val0_i(val0), .stamp0_i(stamp0),
    .req1_i(req1), .pc1_i(pc1), .insn1_i(insn1), .cmp1_i(cmp1),
    .rd1_i(rd1), .val1_i(val1), .stamp1_i(stamp1),
    .full_i(full_o), .gnt0_o(gnt0), .gnt1_o(gnt1),
    .wr_en_o(wr_en), .wr_hart_o(wr_hart), .wr_pc_o(wr_pc), .wr_insn_o(wr_insn),
    .wr_cmp_o(wr_cmp), .wr_rd_o(wr_rd), .wr_val_o(wr_val), .wr_stamp_o(wr_stamp)
  );

  trace_buffer buffer_i (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .wr_en_i(wr_en), .wr_hart_i(wr_hart), .wr_pc_i(wr_pc), .wr_insn_i(wr_insn),
    .wr_cmp_i(wr_cmp), .wr_rd_i(wr_rd), .wr_val_i(wr_val), .wr_stamp_i(wr_stamp),
    .clear_i(clear_i), .rd_idx_i(rd_idx_i),
    .count_o(count_o), .full_o(full_o),
    .rd_hart_o(rd_hart_o), .rd_pc_o(rd_pc_o), .rd_insn_o(rd_insn_o),
    .rd_cmp_o(rd_cmp_o), .rd_rd_o(rd_rd_o), .rd_val_o(rd_val_o),
    .rd_stamp_o(rd_stamp_o)
  );

endmodule

`default_nettype wire

//--- hdl/rvc_expander.sv
// ************************************************
// RVC expander
// Maps a subset of compressed instructions to
// their 32-bit base encoding
// ************************************************

`default_nettype none

module rvc_expander (
  input  rvfi_pkg::insn_t insn_i,
  output rvfi_pkg::insn_t insn_o,
  output logic            compressed_o,
  output logic            expanded_o
);

  logic [2:0]  funct3;
  logic [4:0]  rd_full;
  logic [4:0]  rs2_full;
  logic [4:0]  creg_lo;
  logic [4:0]  creg_hi;
  logic [11:0] imm6;

  assign funct3   = insn_i[15:13];
  assign rd_full  = insn_i[11:7];
  assign rs2_full = insn_i[6:2];

  // Three-bit register fields address x8..x15
  assign creg_lo = {2'b01, insn_i[4:2]};
  assign creg_hi = {2'b01, insn_i[9:7]};

  // Sign-extended six-bit immediate of C.ADDI and C.LI
  assign imm6 = {{7{insn_i[12]}}, insn_i[6:2]};

  assign compressed_o = (insn_i[1:0] != 2'b11);

  always_comb begin
    insn_o     = compressed_o ? {16'h0000, insn_i[15:0]} : insn_i;
    expanded_o = 1'b0;
    if (compressed_o) begin
      expanded_o = 1'b1;
      case ({insn_i[1:0], funct3})
        // C.LW
        5'b00_010: begin
          insn_o = {5'b0, insn_i[5], insn_i[12:10], insn_i[6], 2'b00,
                    creg_hi, 3'b010, creg_lo, 7'b0000011};
        end
        // C.SW
        5'b00_110: begin
          insn_o = {5'b0, insn_i[5], insn_i[12], creg_lo, creg_hi, 3'b010,
                    insn_i[11:10], insn_i[6], 2'b00, 7'b0100011};
        end
        // C.ADDI
        5'b01_000: begin
          insn_o = {imm6, rd_full, 3'b000, rd_full, 7'b0010011};
        end
        // C.LI becomes addi rd, x0, imm
        5'b01_010: begin
          insn_o = {imm6, 5'b0, 3'b000, rd_full, 7'b0010011};
        end
        // C.LUI, rd of x2 is C.ADDI16SP and stays raw
        5'b01_011: begin
          if (rd_full != 5'd2) begin
            insn_o = {{15{insn_i[12]}}, insn_i[6:2], rd_full, 7'b0110111};
          end else begin
            expanded_o = 1'b0;
          end
        end
        // C.J becomes jal x0, offset
        5'b01_101: begin
          insn_o = {insn_i[12], insn_i[8], insn_i[10:9], insn_i[6], insn_i[7],
                    insn_i[2], insn_i[11], insn_i[5:3], insn_i[12],
                    {8{insn_i[12]}}, 5'b0, 7'b1101111};
        end
        // C.BEQZ becomes beq rs1', x0, offset
        5'b01_110: begin
          insn_o = {insn_i[12], {3{insn_i[12]}}, insn_i[6:5], insn_i[2], 5'b0,
                    creg_hi, 3'b000, insn_i[11:10], insn_i[4:3], insn_i[12],
                    7'b1100011};
        end
        // C.MV and C.ADD, a zero rs2 encodes the jump forms
        5'b10_100: begin
          if (rs2_full == 5'd0) begin
            expanded_o = 1'b0;
          end else if (insn_i[12]) begin
            insn_o = {7'b0, rs2_full, rd_full, 3'b000, rd_full, 7'b0110011};
          end else begin
            insn_o = {7'b0, rs2_full, 5'b0, 3'b000, rd_full, 7'b0110011};
          end
        end
        default: begin
          expanded_o = 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/rvfi_pkg.sv
// ************************************************
// RVFI types
// Retirement data as presented by each hart
// ************************************************

`default_nettype none

`include "retire_trace_consts.svh"

package rvfi_pkg;

  // PC and register data word
  typedef logic [`RT_XLEN-1:0] xlen_t;

  // Instruction word
  // A compressed parcel sits in the low half
  typedef logic [31:0] insn_t;

  // Architectural register number
  typedef logic [4:0] reg_addr_t;

  // Destination tag, top bit selects the FP register file
  typedef logic [5:0] reg_idx_t;

endpackage

`default_nettype wire

//--- hdl/trace_arbiter.sv
// ************************************************
// Trace arbiter
// Round-robin grant of the shared buffer write port
// between the two packers
// ************************************************

`default_nettype none

module trace_arbiter (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req0_i,
  input  rvfi_pkg::xlen_t    pc0_i,
  input  rvfi_pkg::insn_t    insn0_i,
  input  logic               cmp0_i,
  input  rvfi_pkg::reg_idx_t rd0_i,
  input  rvfi_pkg::xlen_t    val0_i,
  input  trace_pkg::stamp_t  stamp0_i,
  input  logic               req1_i,
  input  rvfi_pkg::xlen_t    pc1_i,
  input  rvfi_pkg::insn_t    insn1_i,
  input  logic               cmp1_i,
  input  rvfi_pkg::reg_idx_t rd1_i,
  input  rvfi_pkg::xlen_t    val1_i,
  input  trace_pkg::stamp_t  stamp1_i,
  input  logic               full_i,
  output logic               gnt0_o,
  output logic               gnt1_o,
  output logic               wr_en_o,
  output logic               wr_hart_o,
  output rvfi_pkg::xlen_t    wr_pc_o,
  output rvfi_pkg::insn_t    wr_insn_o,
  output logic               wr_cmp_o,
  output rvfi_pkg::reg_idx_t wr_rd_o,
  output rvfi_pkg::xlen_t    wr_val_o,
  output trace_pkg::stamp_t  wr_stamp_o
);

  trace_pkg::grant_last_e last_q;

  // On a tie the hart that waited longer wins
  assign gnt0_o = !full_i && req0_i && (!req1_i || (last_q == trace_pkg::LAST_HART1));
  assign gnt1_o = !full_i && req1_i && (!req0_i || (last_q == trace_pkg::LAST_HART0));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= trace_pkg::LAST_HART1;
    end else if (gnt0_o) begin
      last_q <= trace_pkg::LAST_HART0;
    end else if (gnt1_o) begin
      last_q <= trace_pkg::LAST_HART1;
    end
  end

  assign wr_en_o    = gnt0_o || gnt1_o;
  assign wr_hart_o  = gnt1_o;
  assign wr_pc_o    = gnt1_o ? pc1_i : pc0_i;
  assign wr_insn_o  = gnt1_o ? insn1_i : insn0_i;
  assign wr_cmp_o   = gnt1_o ? cmp1_i : cmp0_i;
  assign wr_rd_o    = gnt1_o ? rd1_i : rd0_i;
  assign wr_val_o   = gnt1_o ? val1_i : val0_i;
  assign wr_stamp_o = gnt1_o ? stamp1_i : stamp0_i;

  a_gnt_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({gnt1_o, gnt0_o}));

  a_gnt_to_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (gnt0_o |-> req0_i) and (gnt1_o |-> req1_i));

endmodule

`default_nettype wire

//--- hdl/trace_buffer.sv
// ************************************************
// Trace buffer
// Record memory filled in write order, read back
// by index from the host
// ************************************************

`default_nettype none

`include "retire_trace_consts.svh"

module trace_buffer (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 wr_en_i,
  input  logic                 wr_hart_i,
  input  rvfi_pkg::xlen_t      wr_pc_i,
  input  rvfi_pkg::insn_t      wr_insn_i,
  input  logic                 wr_cmp_i,
  input  rvfi_pkg::reg_idx_t   wr_rd_i,
  input  rvfi_pkg::xlen_t      wr_val_i,
  input  trace_pkg::stamp_t    wr_stamp_i,
  input  logic                 clear_i,
  input  trace_pkg::buf_idx_t  rd_idx_i,
  output trace_pkg::buf_cnt_t  count_o,
  output logic                 full_o,
  output logic                 rd_hart_o,
  output rvfi_pkg::xlen_t      rd_pc_o,
  output rvfi_pkg::insn_t      rd_insn_o,
  output logic                 rd_cmp_o,
  output rvfi_pkg::reg_idx_t   rd_rd_o,
  output rvfi_pkg::xlen_t      rd_val_o,
  output trace_pkg::stamp_t    rd_stamp_o
);

  trace_pkg::buf_cnt_t count_q;
  trace_pkg::buf_idx_t wr_idx;
  logic                wr_take;

  logic               hart_mem  [`RT_DEPTH];
  rvfi_pkg::xlen_t    pc_mem    [`RT_DEPTH];
  rvfi_pkg::insn_t    insn_mem  [`RT_DEPTH];
  logic               cmp_mem   [`RT_DEPTH];
  rvfi_pkg::reg_idx_t rd_mem    [`RT_DEPTH];
  rvfi_pkg::xlen_t    val_mem   [`RT_DEPTH];
  trace_pkg::stamp_t  stamp_mem [`RT_DEPTH];

  assign full_o = (count_q == trace_pkg::buf_cnt_t'(`RT_DEPTH));

  // A write that meets a clear lands in the first entry
  assign wr_idx  = clear_i ? '0 : count_q[`RT_DEPTH_W-1:0];
  assign wr_take = wr_en_i && (clear_i || !full_o);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= trace_pkg::buf_cnt_t'(wr_take);
    end else if (wr_take) begin
      count_q <= count_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_take) begin
      hart_mem[wr_idx]  <= wr_hart_i;
      pc_mem[wr_idx]    <= wr_pc_i;
      insn_mem[wr_idx]  <= wr_insn_i;
      cmp_mem[wr_idx]   <= wr_cmp_i;
      rd_mem[wr_idx]    <= wr_rd_i;
      val_mem[wr_idx]   <= wr_val_i;
      stamp_mem[wr_idx] <= wr_stamp_i;
    end
  end

  assign count_o    = count_q;
  assign rd_hart_o  = hart_mem[rd_idx_i];
  assign rd_pc_o    = pc_mem[rd_idx_i];
  assign rd_insn_o  = insn_mem[rd_idx_i];
  assign rd_cmp_o   = cmp_mem[rd_idx_i];
  assign rd_rd_o    = rd_mem[rd_idx_i];
  assign rd_val_o   = val_mem[rd_idx_i];
  assign rd_stamp_o = stamp_mem[rd_idx_i];

  // The arbiter holds off grants while we report full
  a_no_write_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    full_o |-> !wr_en_i);

endmodule

`default_nettype wire

//--- hdl/trace_pkg.sv
// ************************************************
// Trace types
// Record stamps, buffer indexing and arbiter state
// ************************************************

`default_nettype none

`include "retire_trace_consts.svh"

package trace_pkg;

  // Cycle stamp of a record
  typedef logic [`RT_STAMP_W-1:0] stamp_t;

  // Buffer entry index and fill count
  typedef logic [`RT_DEPTH_W-1:0] buf_idx_t;
  typedef logic [`RT_DEPTH_W:0] buf_cnt_t;

  // Saturating count of lost retirements
  typedef logic [7:0] drop_cnt_t;

  // Hart that received the most recent grant
  typedef enum logic {
    LAST_HART0,
    LAST_HART1
  } grant_last_e;

endpackage

`default_nettype wire

//--- retire_trace.f
+incdir+hdl
hdl/rvfi_pkg.sv
hdl/trace_pkg.sv
hdl/rvc_expander.sv
hdl/retire_packer.sv
hdl/trace_arbiter.sv
hdl/trace_buffer.sv
hdl/retire_trace_top.sv
sim/tb_retire_trace.sv

//--- sim/tb_retire_trace.sv
// ************************************************
// Retire trace testbench
// Drives both hart ports, models the records and
// checks the buffer contents and status
// ************************************************

`default_nettype none

`include "retire_trace_consts.svh"

module tb_retire_trace;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int timeout_cycles = 2000;

  logic clk_i;
  logic rst_ni;
  logic rvfi0_valid_i, rvfi0_frd_wvalid_i, rvfi1_valid_i, rvfi1_frd_wvalid_i;
  logic [31:0] rvfi0_insn_i, rvfi0_pc_i, rvfi0_rd_wdata_i, rvfi0_frd_wdata_i;
  logic [31:0] rvfi1_insn_i, rvfi1_pc_i, rvfi1_rd_wdata_i, rvfi1_frd_wdata_i;
  logic [4:0]  rvfi0_rd_addr_i, rvfi0_frd_addr_i, rvfi1_rd_addr_i, rvfi1_frd_addr_i;
  logic        clear_i;
  logic [3:0]  rd_idx_i;
  logic [4:0]  count_o;
  logic        full_o, rd_hart_o, rd_cmp_o;
  logic [31:0] rd_pc_o, rd_insn_o, rd_val_o;
  logic [5:0]  rd_rd_o;
  logic [15:0] rd_stamp_o;
  logic [7:0]  drop0_o, drop1_o;

  // Reference model state
  logic [15:0] model_cycle;
  logic [31:0] e_pc [2];
  logic [31:0] e_insn [2];
  logic        e_cmp [2];
  logic [5:0]  e_tag [2];
  logic [31:0] e_val [2];
  logic [15:0] e_stamp [2];
  logic [15:0] c_words [9];
  logic [31:0] x_words [9];
  int          last_hart;
  int          errors;
  int          checks;
  int          tests;
  int          cycles;

  retire_trace_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      model_cycle <= '0;
    end else begin
      model_cycle <= model_cycle + 1'b1;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("timeout, the run did not finish within %0d cycles", timeout_cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  a_full_flag : assert property (@(posedge clk_i) disable iff (!rst_ni)
    full_o == (count_o == `RT_DEPTH)) else begin
    errors++;
    $display("full flag disagrees with the fill count");
  end

  // Once full the count holds until the host clears
  a_full_holds : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (full_o && !clear_i) |=> (count_o == `RT_DEPTH)) else begin
    errors++;
    $display("fill count moved while the buffer was full");
  end

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %s finished, errors so far %0d", name, errors);
  endtask

  task automatic clear_buffer();
    step();
    clear_i = 1'b1;
    step();
    clear_i = 1'b0;
    check("count_o", count_o, 0);
  endtask

  // Drives one retirement and records what the buffer should hold
  task automatic set_hart(input int hart, input logic [31:0] insn,
                          input logic [31:0] x_insn, input logic cmp, input logic fv);
    logic [31:0] pc;
    logic [31:0] wd;
    logic [31:0] fd;
    logic [4:0]  rd;
    logic [4:0]  frd;
    pc  = $urandom;
    wd  = $urandom;
    fd  = $urandom;
    rd  = 5'($urandom);
    frd = 5'($urandom);
    e_pc[hart]    = pc;
    e_insn[hart]  = x_insn;
    e_cmp[hart]   = cmp;
    e_tag[hart]   = fv ? {1'b1, frd} : {1'b0, rd};
    e_val[hart]   = fv ? fd : wd;
    e_stamp[hart] = model_cycle;
    if (hart == 0) begin
      rvfi0_valid_i = 1'b1;
      rvfi0_insn_i = insn;
      rvfi0_pc_i = pc;
      rvfi0_rd_addr_i = rd;
      rvfi0_rd_wdata_i = wd;
      rvfi0_frd_wvalid_i = fv;
      rvfi0_frd_addr_i = frd;
      rvfi0_frd_wdata_i = fd;
    end else begin
      rvfi1_valid_i = 1'b1;
      rvfi1_insn_i = insn;
      rvfi1_pc_i = pc;
      rvfi1_rd_addr_i = rd;
      rvfi1_rd_wdata_i = wd;
      rvfi1_frd_wvalid_i = fv;
      rvfi1_frd_addr_i = frd;
      rvfi1_frd_wdata_i = fd;
    end
  endtask

  task automatic release_harts();
    rvfi0_valid_i = 1'b0;
    rvfi1_valid_i = 1'b0;
  endtask

  task automatic check_entry(input logic [4:0] idx, input int hart);
    rd_idx_i = idx[3:0];
    #1;
    check("rd_hart_o", rd_hart_o, hart);
    check("rd_pc_o", rd_pc_o, e_pc[hart]);
    check("rd_insn_o", rd_insn_o, e_insn[hart]);
    check("rd_cmp_o", rd_cmp_o, e_cmp[hart]);
    check("rd_rd_o", rd_rd_o, e_tag[hart]);
    check("rd_val_o", rd_val_o, e_val[hart]);
    check("rd_stamp_o", rd_stamp_o, e_stamp[hart]);
  endtask

  // Lone retirement on one hart, written two cycles after the retire edge
  task automatic retire_one(input int hart, input logic [31:0] insn,
                            input logic [31:0] x_insn, input logic cmp, input logic fv);
    logic [4:0] old;
    step();
    old = count_o;
    set_hart(hart, insn, x_insn, cmp, fv);
    step();
    release_harts();
    check("count_o", count_o, old);
    step();
    check("count_o", count_o, old);
    step();
    check("count_o", count_o, old + 1'b1);
    check_entry(old, hart);
    last_hart = hart;
  endtask

  task automatic retire_both();
    logic [4:0] old;
    int first;
    step();
    old = count_o;
    first = (last_hart == 0) ? 1 : 0;
    set_hart(0, 32'h0000_0013, 32'h0000_0013, 1'b0, 1'b0);
    set_hart(1, 32'h00b5_0533, 32'h00b5_0533, 1'b0, 1'b1);
    step();
    release_harts();
    while (count_o != old + 2'd2) begin
      step();
    end
    check_entry(old, first);
    check_entry(old + 1'b1, 1 - first);
    last_hart = 1 - first;
  endtask

  function automatic logic [31:0] i_enc(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  // Compressed forms built from fields, next to their base encodings
  task automatic build_rvc();
    logic [6:0]  lo;
    logic [11:0] jo;
    logic [20:0] ji;
    logic [8:0]  bo;
    logic [12:0] bi;
    c_words[0] = {3'b000, 1'b1, 5'd9, 5'b11011, 2'b01};
    x_words[0] = i_enc(12'hffb, 5'd9, 3'b000, 5'd9, 7'h13);
    c_words[1] = {3'b010, 1'b0, 5'd12, 5'b10001, 2'b01};
    x_words[1] = i_enc(12'd17, 5'd0, 3'b000, 5'd12, 7'h13);
    c_words[2] = {3'b011, 1'b1, 5'd7, 5'b00001, 2'b01};
    x_words[2] = {{14{1'b1}}, 6'h21, 5'd7, 7'h37};
    lo = 7'h4c;
    c_words[3] = {3'b010, lo[5:3], 3'd1, lo[2], lo[6], 3'd2, 2'b00};
    x_words[3] = i_enc({5'b0, lo}, 5'd9, 3'b010, 5'd10, 7'h03);
    lo = 7'h38;
    c_words[4] = {3'b110, lo[5:3], 3'd3, lo[2], lo[6], 3'd6, 2'b00};
    x_words[4] = {5'b0, lo[6:5], 5'd14, 5'd11, 3'b010, lo[4:0], 7'h23};
    c_words[5] = {3'b100, 1'b0, 5'd5, 5'd11, 2'b10};
    x_words[5] = {7'b0, 5'd11, 5'd0, 3'b000, 5'd5, 7'h33};
    c_words[6] = {3'b100, 1'b1, 5'd5, 5'd11, 2'b10};
    x_words[6] = {7'b0, 5'd11, 5'd5, 3'b000, 5'd5, 7'h33};
    jo = 12'hf9c;
    ji = {{9{jo[11]}}, jo};
    c_words[7] = {3'b101, jo[11], jo[4], jo[9:8], jo[10], jo[6], jo[7], jo[3:1], jo[5],
                  2'b01};
    x_words[7] = {ji[20], ji[10:1], ji[11], ji[19:12], 5'd0, 7'h6f};
    bo = 9'h1f4;
    bi = {{4{bo[8]}}, bo};
    c_words[8] = {3'b110, bo[8], bo[4:3], 3'd4, bo[7:6], bo[2:1], bo[5], 2'b01};
    x_words[8] = {bi[12], bi[10:5], 5'd0, 5'd12, 3'b000, bi[4:1], bi[11], 7'h63};
  endtask

  initial begin
    int unsigned seed_dummy;
    int retired;
    int drained;
    logic [4:0] prev;
    seed_dummy = $urandom(32'h5cc5);
    errors = 0;
    checks = 0;
    tests = 0;
    cycles = 0;
    last_hart = 1;
    rst_ni = 1'b0;
    clear_i = 1'b0;
    rd_idx_i = '0;
    {rvfi0_valid_i, rvfi0_frd_wvalid_i, rvfi1_valid_i, rvfi1_frd_wvalid_i} = '0;
    {rvfi0_insn_i, rvfi0_pc_i, rvfi0_rd_wdata_i, rvfi0_frd_wdata_i} = '0;
    {rvfi1_insn_i, rvfi1_pc_i, rvfi1_rd_wdata_i, rvfi1_frd_wdata_i} = '0;
    {rvfi0_rd_addr_i, rvfi0_frd_addr_i, rvfi1_rd_addr_i, rvfi1_frd_addr_i} = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check("count_o", count_o, 0);
    check("full_o", full_o, 0);
    check("drop0_o", drop0_o, 0);
    check("drop1_o", drop1_o, 0);

    repeat (4) retire_one(0, 32'h00c5_8533, 32'h00c5_8533, 1'b0, 1'b0);
    finish_test("single hart order and timing");

    clear_buffer();
    build_rvc();
    for (int i = 0; i < 9; i++) begin
      retire_one(0, {16'h5a5a, c_words[i]}, x_words[i], 1'b1, 1'b0);
    end
    retire_one(0, 32'hdead_0506, 32'h0000_0506, 1'b1, 1'b0);
    retire_one(0, 32'h00a5_0533, 32'h00a5_0533, 1'b0, 1'b0);
    finish_test("compressed expansion");

    clear_buffer();
    retire_one(0, 32'h0020_f053, 32'h0020_f053, 1'b0, 1'b1);
    retire_one(0, 32'h0020_f053, 32'h0020_f053, 1'b0, 1'b0);
    finish_test("destination select");

    clear_buffer();
    retire_both();
    retire_one(1, 32'h0020_0093, 32'h0020_0093, 1'b0, 1'b0);
    retire_both();
    check("drop0_o", drop0_o, 0);
    check("drop1_o", drop1_o, 0);
    finish_test("dual hart round robin");

    clear_buffer();
    retired = 0;
    for (int i = 0; i < 20; i++) begin
      set_hart(0, 32'h0000_0013, 32'h0000_0013, 1'b0, 1'b0);
      set_hart(1, 32'h0000_0013, 32'h0000_0013, 1'b0, 1'b0);
      retired += 2;
      step();
    end
    release_harts();
    repeat (4) step();
    check("full_o", full_o, 1);
    check("count_o", count_o, `RT_DEPTH);
    checks++;
    assert ((drop0_o != 0) && (drop1_o != 0)) else begin
      errors++;
      $display("a full queue did not count dropped retirements on both harts");
    end
    clear_buffer();
    prev = '1;
    while (count_o != prev) begin
      prev = count_o;
      repeat (3) step();
    end
    drained = count_o;
    check("count_o", count_o, 2 * `RT_QUEUE_DEPTH);
    checks++;
    assert (`RT_DEPTH + drop0_o + drop1_o + drained == retired) else begin
      errors++;
      $display("stored, dropped and queued records do not add up to the retirements");
    end
    finish_test("full buffer, drops and clear");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
